// File: logic/sportPkg.sv
package sportPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    RegCtrl   = 2'd0,  // Control bits
    RegClkDiv = 2'd1,  // Bit clock divider
    RegFsDiv  = 2'd2,  // Frame period in bits, minus one
    RegTxData = 2'd3   // Transmit word
  } sportRegAddr;

  typedef enum logic {
    ShiftIdle = 1'b0,
    ShiftBusy = 1'b1
  } shiftState;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int DivWidth = 16;
  localparam int LenWidth = 4;   // Word length is field + 1
  localparam int DlyWidth = 2;

  // Control register layout
  localparam int CtrlEnableBit  = 0;
  localparam int CtrlSclkInvBit = 1;
  localparam int CtrlFsInvBit   = 2;
  localparam int CtrlFsWideBit  = 3;
  localparam int CtrlDelayLsb   = 4;
  localparam int CtrlLenLsb     = 8;

endpackage

// File: logic/sportCfgIf.sv
`timescale 1ns/1ps

interface sportCfgIf #(
  parameter int DataWidth = 16
);
  import sportPkg::*;

  logic                 enable;
  logic                 sclkInvert;
  logic                 fsInvert;
  logic                 fsWide;
  logic [DlyWidth-1:0]  fsDelay;
  logic [LenWidth-1:0]  wordLen;
  logic [DivWidth-1:0]  clkDiv;
  logic [DivWidth-1:0]  fsDiv;
  logic [DataWidth-1:0] txWord;
  logic                 txPending;  // Word written, not yet loaded
  logic                 txTake;

  modport regs (
    output enable, sclkInvert, fsInvert, fsWide, fsDelay, wordLen,
    output clkDiv, fsDiv, txWord, txPending,
    input  txTake
  );

  modport gen (
    input enable, sclkInvert, fsInvert, fsWide, fsDelay, wordLen, clkDiv, fsDiv
  );

  modport shift (
    input  enable, wordLen, txWord, txPending,
    output txTake
  );

endinterface

// File: logic/sportCfgRegs.sv
`timescale 1ns/1ps

module sportCfgRegs #(
  parameter int DataWidth = 16
) (
  input  logic                  SCLKg2,
  input  logic                  RST,
  input  logic                  cfgWe,
  input  sportPkg::sportRegAddr cfgAddr,
  input  logic [DataWidth-1:0]  cfgWdata,
  sportCfgIf.regs               cfg
);
  import sportPkg::*;

  logic txWrite;

  assign txWrite = cfgWe && (cfgAddr == RegTxData);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge SCLKg2 or posedge RST) begin
    if (RST) begin
      cfg.enable     <= 1'b0;
      cfg.sclkInvert <= 1'b0;
      cfg.fsInvert   <= 1'b0;
      cfg.fsWide     <= 1'b0;
      cfg.fsDelay    <= '0;
      cfg.wordLen    <= '0;
      cfg.clkDiv     <= '0;
      cfg.fsDiv      <= '0;
      cfg.txWord     <= '0;
    end else if (cfgWe) begin
      case (cfgAddr)
        RegCtrl: begin
          cfg.enable     <= cfgWdata[CtrlEnableBit];
          cfg.sclkInvert <= cfgWdata[CtrlSclkInvBit];
          cfg.fsInvert   <= cfgWdata[CtrlFsInvBit];
          cfg.fsWide     <= cfgWdata[CtrlFsWideBit];
          cfg.fsDelay    <= cfgWdata[CtrlDelayLsb +: DlyWidth];
          cfg.wordLen    <= cfgWdata[CtrlLenLsb +: LenWidth];
        end
        RegClkDiv: begin
          cfg.clkDiv <= cfgWdata[DivWidth-1:0];
        end
        RegFsDiv: begin
          cfg.fsDiv <= cfgWdata[DivWidth-1:0];
        end
        RegTxData: begin
          cfg.txWord <= cfgWdata;
        end
      endcase
    end
  end

  // Pending flag, a fresh write beats the shifter taking the old word
  always_ff @(posedge SCLKg2 or posedge RST) begin
    if (RST) begin
      cfg.txPending <= 1'b0;
    end else if (txWrite) begin
      cfg.txPending <= 1'b1;
    end else if (cfg.txTake) begin
      cfg.txPending <= 1'b0;
    end
  end

  cfgAddrKnown: assert property (
    @(posedge SCLKg2) disable iff (RST)
    cfgWe |-> !$isunknown(cfgAddr)
  ) else $error("cfgAddr unknown during a register write");

endmodule

// File: logic/sportFrameGen.sv
`timescale 1ns/1ps

module sportFrameGen (
  input  logic   SCLKg2,
  input  logic   RST,
  sportCfgIf.gen cfg,
  output logic   bitTick,
  output logic   frameStart,
  output logic   sclkOut,
  output logic   fsOut
);
  import sportPkg::*;

  logic [DivWidth-1:0] divCnt;
  logic                divMatch;
  logic                sclkInt;
  logic [DivWidth-1:0] fsCnt;
  logic                fsSet;
  logic                fsInt;
  logic                fsIntNext;
  logic [LenWidth-1:0] widthCnt;
  logic [2:0]          dlyLine;
  logic                fsDly;
  logic                fsDlyNext;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit clock divider
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign divMatch = (divCnt >= cfg.clkDiv);
  assign bitTick  = cfg.enable && divMatch && !sclkInt;  // Bit clock rises at this edge

  always_ff @(posedge SCLKg2 or posedge RST) begin
    if (RST) begin
      divCnt  <= '0;
      sclkInt <= 1'b0;
    end else if (!cfg.enable) begin
      divCnt  <= '0;
      sclkInt <= 1'b0;
    end else if (divMatch) begin
      divCnt  <= '0;
      sclkInt <= !sclkInt;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  assign sclkOut = sclkInt ^ cfg.sclkInvert;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame counter and sync width
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign fsSet = (fsCnt >= cfg.fsDiv);

  always_comb begin
    fsIntNext = fsInt;
    if (fsSet) begin
      fsIntNext = 1'b1;
    end else if (fsInt && (widthCnt == '0)) begin
      fsIntNext = 1'b0;  // Last bit of the sync
    end
  end

  always_ff @(posedge SCLKg2 or posedge RST) begin
    if (RST) begin
      fsCnt    <= '0;
      fsInt    <= 1'b0;
      widthCnt <= '0;
      dlyLine  <= '0;
    end else if (!cfg.enable) begin
      fsCnt    <= cfg.fsDiv;  // First tick after enable opens a frame
      fsInt    <= 1'b0;
      widthCnt <= '0;
      dlyLine  <= '0;
    end else if (bitTick) begin
      fsCnt   <= fsSet ? '0 : fsCnt + 1'b1;
      fsInt   <= fsIntNext;
      dlyLine <= {dlyLine[1:0], fsInt};
      if (fsSet) begin
        widthCnt <= cfg.fsWide ? cfg.wordLen : '0;
      end else if (widthCnt != '0) begin
        widthCnt <= widthCnt - 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sync delay and frame start
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign fsDly = (cfg.fsDelay == 2'd0) ? fsInt :
                 (cfg.fsDelay == 2'd1) ? dlyLine[0] :
                 (cfg.fsDelay == 2'd2) ? dlyLine[1] : dlyLine[2];

  // Same tap one tick ahead, so the start lines up with the sync edge
  assign fsDlyNext = (cfg.fsDelay == 2'd0) ? fsIntNext :
                     (cfg.fsDelay == 2'd1) ? fsInt :
                     (cfg.fsDelay == 2'd2) ? dlyLine[0] : dlyLine[1];

  assign frameStart = bitTick && fsDlyNext && !fsDly;
  assign fsOut      = fsDly ^ cfg.fsInvert;

  // Lookahead tap agrees with the delay line once a frame opens
  frameRaisesSync: assert property (
    @(posedge SCLKg2) disable iff (RST)
    frameStart |=> (fsDly || !cfg.enable || !$stable(cfg.fsDelay))
  ) else $error("delayed sync still low after frameStart");

endmodule

// File: logic/sportShifter.sv
`timescale 1ns/1ps

module sportShifter #(
  parameter int DataWidth = 16
) (
  input  logic                 SCLKg2,
  input  logic                 RST,
  sportCfgIf.shift             cfg,
  input  logic                 bitTick,
  input  logic                 frameStart,
  input  logic                 rxd,
  output logic                 txd,
  output logic [DataWidth-1:0] rxWord,
  output logic                 rxValid
);
  import sportPkg::*;

  shiftState            state;
  logic [LenWidth-1:0]  bitCnt;
  logic [DataWidth-1:0] txShift;
  logic [DataWidth-1:0] rxShift;
  logic [DataWidth-1:0] loadWord;
  logic                 busyTick;
  logic                 lastTick;
  logic                 loadNow;

  assign busyTick = (state == ShiftBusy) && bitTick;
  assign lastTick = busyTick && (bitCnt == '0);

  // A new frame may open on the tick that closes the previous word
  assign loadNow    = cfg.enable && frameStart && ((state == ShiftIdle) || lastTick);
  assign cfg.txTake = loadNow;

  // Left-align so the word's MSB sits at the top of the shifter
  assign loadWord = (cfg.txPending ? cfg.txWord : '0) << (DataWidth - 1 - int'(cfg.wordLen));

  assign txd = (state == ShiftBusy) && txShift[DataWidth-1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word FSM and shift registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge SCLKg2 or posedge RST) begin
    if (RST) begin
      state   <= ShiftIdle;
      bitCnt  <= '0;
      txShift <= '0;
      rxShift <= '0;
    end else if (!cfg.enable) begin
      state   <= ShiftIdle;
      bitCnt  <= '0;
      txShift <= '0;
      rxShift <= '0;
    end else if (loadNow) begin
      state   <= ShiftBusy;
      bitCnt  <= cfg.wordLen;
      txShift <= loadWord;
      rxShift <= '0;  // Keeps the received word right-justified
    end else if (busyTick) begin
      txShift <= txShift << 1;
      rxShift <= {rxShift[DataWidth-2:0], rxd};  // Sample at the end of each bit
      if (lastTick) begin
        state <= ShiftIdle;
      end else begin
        bitCnt <= bitCnt - 1'b1;
      end
    end
  end

  // Completed word
  always_ff @(posedge SCLKg2 or posedge RST) begin
    if (RST) begin
      rxWord  <= '0;
      rxValid <= 1'b0;
    end else begin
      rxValid <= lastTick;
      if (lastTick) begin
        rxWord <= {rxShift[DataWidth-2:0], rxd};
      end
    end
  end

  rxValidPulse: assert property (
    @(posedge SCLKg2) disable iff (RST)
    rxValid |=> !rxValid
  ) else $error("rxValid held for more than one cycle");

endmodule

// File: logic/sportTop.sv
`timescale 1ns/1ps

module sportTop #(
  parameter int DataWidth = 16
) (
  input  logic                 SCLKg2,
  input  logic                 RST,
  input  logic                 cfgWe,
  input  logic [1:0]           cfgAddr,
  input  logic [DataWidth-1:0] cfgWdata,
  output logic                 sclkOut,
  output logic                 fsOut,
  output logic                 txd,
  input  logic                 rxd,
  output logic [DataWidth-1:0] rxWord,
  output logic                 rxValid
);
  import sportPkg::*;

  logic bitTick;
  logic frameStart;  // Always on a bitTick

  sportCfgIf #(.DataWidth(DataWidth)) cfgIf ();

  sportCfgRegs #(.DataWidth(DataWidth)) uRegs (
    .SCLKg2   (SCLKg2),
    .RST      (RST),
    .cfgWe    (cfgWe),
    .cfgAddr  (sportRegAddr'(cfgAddr)),
    .cfgWdata (cfgWdata),
    .cfg      (cfgIf)
  );

  sportFrameGen uFrameGen (
    .SCLKg2     (SCLKg2),
    .RST        (RST),
    .cfg        (cfgIf),
    .bitTick    (bitTick),
    .frameStart (frameStart),
    .sclkOut    (sclkOut),
    .fsOut      (fsOut)
  );

  sportShifter #(.DataWidth(DataWidth)) uShifter (
    .SCLKg2     (SCLKg2),
    .RST        (RST),
    .cfg        (cfgIf),
    .bitTick    (bitTick),
    .frameStart (frameStart),
    .rxd        (rxd),
    .txd        (txd),
    .rxWord     (rxWord),
    .rxValid    (rxValid)
  );

endmodule

// File: dv/sportTb.sv
`timescale 1ns/1ps

module sportTb;

  localparam int DataWidth = 16;

  logic                 SCLKg2;
  logic                 RST;
  logic                 cfgWe;
  logic [1:0]           cfgAddr;
  logic [DataWidth-1:0] cfgWdata;
  logic                 sclkOut;
  logic                 fsOut;
  logic                 txd;
  logic                 rxd;
  logic [DataWidth-1:0] rxWord;
  logic                 rxValid;

  // Mirror of the written configuration
  logic [15:0] ctrlSh;
  logic [15:0] clkDivSh;
  logic [15:0] fsDivSh;

  int   cycleNo;
  int   bitRises;     // Bit clock rising edges so far
  int   enableRises;
  logic freshEnable;  // No sync seen since enable went high
  logic prevSclk;
  logic curSclk;
  logic prevFs;
  logic curFs;
  logic riseNow;

  sportTop #(.DataWidth(DataWidth)) DUT (
    .SCLKg2   (SCLKg2),
    .RST      (RST),
    .cfgWe    (cfgWe),
    .cfgAddr  (cfgAddr),
    .cfgWdata (cfgWdata),
    .sclkOut  (sclkOut),
    .fsOut    (fsOut),
    .txd      (txd),
    .rxd      (rxd),
    .rxWord   (rxWord),
    .rxValid  (rxValid)
  );

  assign rxd = txd;  // Loopback

  always #5 SCLKg2 = ~SCLKg2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reporting and cycle stepping
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic nextCycle();
    @(posedge SCLKg2);
    #1;
    cycleNo++;
    prevSclk = curSclk;
    prevFs   = curFs;
    curSclk  = sclkOut;
    curFs    = fsOut;
    riseNow  = (curSclk != prevSclk) && (curSclk != ctrlSh[1]);  // Internal clock went high
    if (riseNow) begin
      bitRises++;
    end
  endtask

  function automatic logic syncActive(input logic level);
    return level ^ ctrlSh[2];
  endfunction

  task automatic writeReg(input logic [1:0] addr, input logic [15:0] data);
    if ((addr == 2'd0) && data[0] && !ctrlSh[0]) begin
      freshEnable = 1'b1;
      enableRises = bitRises;
    end
    if (addr == 2'd0) begin
      ctrlSh = data;
    end else if (addr == 2'd1) begin
      clkDivSh = data;
    end else if (addr == 2'd2) begin
      fsDivSh = data;
    end
    cfgWe    = 1'b1;
    cfgAddr  = addr;
    cfgWdata = data;
    nextCycle();
    cfgWe = 1'b0;
  endtask

  task automatic waitSyncEdge(input int limit);
    int waited;
    waited = 0;
    while (!(syncActive(curFs) && !syncActive(prevFs))) begin
      if (waited >= limit) begin
        abortRun("Timeout: the frame sync edge on fsOut never came");
      end
      nextCycle();
      waited++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame and quiet checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic checkFrames(input int nBits, input logic [31:0] word, input int nFrames);
    int          bitCycles;
    int          period;
    int          width;
    int          limit;
    int          lastEdge;
    int          lastToggle;
    int          bitIdx;
    int          activeLen;
    int          waited;
    logic        sampleNext;
    logic        widthDone;
    logic        gotRx;
    logic [31:0] expWord;
    bitCycles = 2 * (int'(clkDivSh) + 1);
    period    = (int'(fsDivSh) + 1) * bitCycles;
    width     = ctrlSh[3] ? bitCycles * (int'(ctrlSh[11:8]) + 1) : bitCycles;
    limit     = 4 * period + 64;
    expWord   = word & ((32'h1 << nBits) - 32'h1);
    lastEdge  = 0;
    for (int f = 0; f < nFrames; f++) begin
      waitSyncEdge(limit);
      if (freshEnable) begin
        // Sync lands on rise number fsDelay + 1 after enable
        checkValue("bit clock rises before fsOut", 32'(ctrlSh[5:4]) + 32'd1,
                   32'(bitRises - enableRises));
        freshEnable = 1'b0;
      end
      if (f > 0) begin
        checkValue("fsOut period", 32'(period), 32'(cycleNo - lastEdge));
      end
      checkValue("sclkOut at sync edge", 32'(!ctrlSh[1]), 32'(curSclk));
      lastEdge   = cycleNo;
      lastToggle = cycleNo;
      bitIdx     = 0;
      activeLen  = 1;
      sampleNext = 1'b1;
      widthDone  = 1'b0;
      gotRx      = 1'b0;
      waited     = 0;
      while (!(widthDone && gotRx && (bitIdx == nBits))) begin
        if (waited >= limit) begin
          abortRun("Timeout: the frame never finished with a received word");
        end
        nextCycle();
        waited++;
        if (curSclk != prevSclk) begin
          checkValue("sclkOut half period", 32'(clkDivSh) + 32'd1, 32'(cycleNo - lastToggle));
          lastToggle = cycleNo;
        end
        if (sampleNext && (bitIdx < nBits)) begin  // One cycle after a bit clock rise
          checkValue("txd", 32'(expWord[nBits - 1 - bitIdx]), 32'(txd));
          bitIdx++;
        end
        sampleNext = riseNow;
        if (!widthDone) begin
          if (syncActive(curFs)) begin
            activeLen++;
          end else begin
            checkValue("fsOut active width", 32'(width), 32'(activeLen));
            widthDone = 1'b1;
          end
        end
        if (rxValid) begin
          if (gotRx) begin
            abortRun("rxValid pulsed twice within one frame");
          end
          checkValue("rxWord", expWord, 32'(rxWord));
          gotRx = 1'b1;
        end
      end
    end
  endtask

  task automatic checkQuiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      nextCycle();
      checkValue("sclkOut", 32'd0, 32'(sclkOut));
      checkValue("fsOut", 32'd0, 32'(fsOut));
      checkValue("txd", 32'd0, 32'(txd));
      checkValue("rxValid", 32'd0, 32'(rxValid));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Record reader
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int          fd;
    int          code;
    int          c;
    int          nBits;
    int          nFrames;
    int          quietLen;
    logic [7:0]  kind;
    logic [31:0] addr;
    logic [31:0] data;
    SCLKg2      = 1'b0;
    RST         = 1'b1;
    cfgWe       = 1'b0;
    cfgAddr     = '0;
    cfgWdata    = '0;
    ctrlSh      = '0;
    clkDivSh    = '0;
    fsDivSh     = '0;
    cycleNo     = 0;
    bitRises    = 0;
    enableRises = 0;
    freshEnable = 1'b0;
    prevSclk    = 1'b0;
    curSclk     = 1'b0;
    prevFs      = 1'b0;
    curFs       = 1'b0;
    riseNow     = 1'b0;
    repeat (8) @(posedge SCLKg2);
    #1;
    RST = 1'b0;
    fd = $fopen("dv/sportTestdata.txt", "r");
    if (fd == 0) begin
      abortRun("Could not open dv/sportTestdata.txt");
    end
    while (!$feof(fd)) begin
      kind = 8'h00;
      code = $fscanf(fd, "%s", kind);
      if (code == 1) begin
        if (kind == "#") begin
          c = $fgetc(fd);
          while ((c != 10) && (c != -1)) begin
            c = $fgetc(fd);
          end
        end else if (kind == "W") begin
          code = $fscanf(fd, "%h %h", addr, data);
          if (code != 2) begin
            abortRun("Malformed write record in the test data");
          end
          writeReg(addr[1:0], data[15:0]);
        end else if (kind == "E") begin
          code = $fscanf(fd, "%d %h %d", nBits, data, nFrames);
          if (code != 3) begin
            abortRun("Malformed expect record in the test data");
          end
          checkFrames(nBits, data, nFrames);
        end else if (kind == "Q") begin
          code = $fscanf(fd, "%d", quietLen);
          if (code != 1) begin
            abortRun("Malformed quiet record in the test data");
          end
          checkQuiet(quietLen);
        end else begin
          abortRun("Unknown record kind in the test data");
        end
      end
    end
    $fclose(fd);
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: verilog.f
logic/sportPkg.sv
logic/sportCfgIf.sv
logic/sportCfgRegs.sv
logic/sportFrameGen.sv
logic/sportShifter.sv
logic/sportTop.sv
dv/sportTb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module sportTb -Mdir obj_dir \
  && ./obj_dir/VsportTb \
  || { echo "simulation did not complete cleanly"; exit 1; }

// File: dv/sportTestdata.txt
# W addr data (hex): register write, addr 0 ctrl, 1 clkDiv, 2 fsDiv, 3 tx word
# E bits word frames (word hex): expected frames, Q cycles: outputs quiet
Q 40
# 8-bit words, fastest bit clock, no delay
W 1 0000
W 2 0009
W 3 00A5
W 0 0701
E 8 00A5 1
E 8 0000 2
W 0 0000
Q 30
# 16-bit words, inverted bit clock, one bit of delay
W 1 0002
W 2 0011
W 3 BEEF
W 0 0F13
E 16 BEEF 1
W 3 1234
E 16 1234 1
E 16 0000 1
W 0 0000
Q 30
# 12-bit words, wide inverted sync, two bits of delay
W 1 0001
W 2 000D
W 3 F5A3
W 0 0B2D
E 12 F5A3 1
E 12 0000 2
W 0 0000
Q 30
# 5-bit words, both outputs inverted, three bits of delay
W 1 0003
W 2 0007
W 3 0016
W 0 0437
E 5 0016 1
E 5 0000 2
W 0 0000
Q 40
# 1-bit words on a slow bit clock
W 1 0004
W 2 0003
W 3 0001
W 0 0001
E 1 0001 1
E 1 0000 3
W 0 0000
Q 40
